/* list.f */
source/cam_sensor_pkg.sv
source/cam_frame_pkg.sv
source/xck_gen.sv
source/reg_serializer.sv
source/pixel_quantizer.sv
source/pixel_packer.sv
source/capture_seq.sv
source/cam_top.sv
verif/cam_tb.sv

/* run.sh */
#!/bin/sh
# build and run the capture controller testbench
verilator --binary --timing -f list.f --top-module cam_tb -o cam_tb_sim \
    && ./obj_dir/cam_tb_sim \
    || exit 1

/* source/cam_frame_pkg.sv */
// pixel level, threshold set, buffer write record and packing constants
package cam_frame_pkg;

    typedef logic [1:0] pix_level_t;

    // ascending thresholds
    typedef struct packed {
        logic [7:0] th0;
        logic [7:0] th1;
        logic [7:0] th2;
    } cam_thresh_t;

    // offset is relative to the start of the current band
    typedef struct packed {
        logic [9:0] offset;
        logic [7:0] data;
    } buf_wr_t;

    localparam int BAND_LINES = 8;

    localparam int PIX_PER_BYTE = 4;

endpackage

/* source/cam_sensor_pkg.sv */
// sensor register set, configuration word layout, load order and exposure scaling
package cam_sensor_pkg;

    // host register bytes as seen by the cartridge
    typedef struct packed {
        logic [7:0] reg_a000;
        logic [7:0] reg_a001;
        logic [7:0] reg_a002;
        logic [7:0] reg_a003;
        logic [7:0] reg_a004;
        logic [7:0] reg_a005;
    } cam_regs_t;

    // one serial word, address goes out first
    typedef struct packed {
        logic [2:0] addr;
        logic [7:0] data;
    } cam_word_t;

    localparam int REG_COUNT = 8;

    // register 0 is loaded last
    localparam logic [2:0] REG_ORDER [REG_COUNT] = '{
        3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd6, 3'd7, 3'd0
    };

    // exposure unit is 8 xck periods
    localparam int EXPO_SHIFT = 3;

endpackage

/* source/cam_top.sv */
// top level with sensor clock, capture FSM, config shifter, quantizer and packer
`timescale 1ns/1ps

module cam_top #(
    parameter int XCK_HALF = 16,
    parameter int SETTLE   = 15,
    parameter int IMG_W    = 128,
    parameter int IMG_H    = 112
) (
    input  logic                       sys_clock,
    input  logic                       sys_resetn,
    input  cam_sensor_pkg::cam_regs_t  cam_regs,
    input  cam_frame_pkg::cam_thresh_t thresh,
    input  logic                       capture_req,
    output logic                       capture_ack,
    input  logic [7:0]                 adc_data,
    output logic                       sens_xck,
    output logic                       sens_reset,
    output logic                       sens_sin,
    output logic                       sens_load,
    output logic                       sens_start,
    output logic                       sens_read,
    output cam_frame_pkg::buf_wr_t     buf_wr,
    output logic                       buf_req,
    input  logic                       buf_ack,
    output logic                       flip_buffer,
    output logic                       block_ready,
    output logic                       buf_overrun
);
    import cam_frame_pkg::*;

    logic       xck_rise;
    logic       xck_fall;
    logic       mid_high;
    logic       mid_low;
    logic       cfg_start;
    logic       cfg_done;
    logic       sample_go;
    logic       frame_start;
    logic       level_valid;
    logic       buf_idle;
    pix_level_t level;

    xck_gen #(.XCK_HALF(XCK_HALF)) u_xck (
        .sys_clock(sys_clock), .sys_resetn(sys_resetn), .sens_xck(sens_xck),
        .xck_rise(xck_rise), .xck_fall(xck_fall), .mid_high(mid_high), .mid_low(mid_low)
    );

    capture_seq #(.IMG_W(IMG_W), .IMG_H(IMG_H)) u_seq (
        .sys_clock(sys_clock), .sys_resetn(sys_resetn), .capture_req(capture_req),
        .cam_regs(cam_regs), .xck_rise(xck_rise), .xck_fall(xck_fall), .mid_low(mid_low),
        .cfg_done(cfg_done), .buf_idle(buf_idle), .capture_ack(capture_ack),
        .cfg_start(cfg_start), .sens_reset(sens_reset), .sens_start(sens_start),
        .sens_read(sens_read), .sample_go(sample_go), .frame_start(frame_start)
    );

    reg_serializer u_cfg (
        .sys_clock(sys_clock), .sys_resetn(sys_resetn), .cam_regs(cam_regs),
        .cfg_start(cfg_start), .xck_rise(xck_rise), .xck_fall(xck_fall),
        .mid_high(mid_high), .sens_sin(sens_sin), .sens_load(sens_load), .cfg_done(cfg_done)
    );

    pixel_quantizer #(.SETTLE(SETTLE)) u_quant (
        .sys_clock(sys_clock), .sys_resetn(sys_resetn), .sample_go(sample_go),
        .adc_data(adc_data), .thresh(thresh), .level(level), .level_valid(level_valid)
    );

    pixel_packer #(.IMG_W(IMG_W)) u_pack (
        .sys_clock(sys_clock), .sys_resetn(sys_resetn), .frame_start(frame_start),
        .level(level), .level_valid(level_valid), .buf_ack(buf_ack), .buf_wr(buf_wr),
        .buf_req(buf_req), .flip_buffer(flip_buffer), .block_ready(block_ready),
        .buf_overrun(buf_overrun), .buf_idle(buf_idle)
    );

endmodule

/* source/capture_seq.sv */
// capture FSM with host handshake, sensor reset, start, exposure and read control
`timescale 1ns/1ps

module capture_seq #(
    parameter int IMG_W = 128,
    parameter int IMG_H = 112
) (
    input  logic                      sys_clock,
    input  logic                      sys_resetn,
    input  logic                      capture_req,
    input  cam_sensor_pkg::cam_regs_t cam_regs,
    input  logic                      xck_rise,
    input  logic                      xck_fall,
    input  logic                      mid_low,
    input  logic                      cfg_done,
    input  logic                      buf_idle,
    output logic                      capture_ack,
    output logic                      cfg_start,
    output logic                      sens_reset,
    output logic                      sens_start,
    output logic                      sens_read,
    output logic                      sample_go,
    output logic                      frame_start
);
    import cam_sensor_pkg::*;

    localparam int NPIX = IMG_W * IMG_H;
    localparam int RW   = $clog2(NPIX);
    localparam int EW   = 16 + EXPO_SHIFT;

    typedef enum logic [3:0] {
        S_IDLE,
        S_RESET,
        S_CONFIG,
        S_START,
        S_EXPOSE,
        S_READ,
        S_DRAIN,
        S_RESET2,
        S_DONE,
        S_RELEASE
    } state_t;

    state_t        state;
    logic          rst_low;
    logic [EW-1:0] expo_len;
    logic [EW-1:0] expo_cnt;
    logic [RW-1:0] read_cnt;

    // exposure in xck periods
    assign expo_len  = EW'({cam_regs.reg_a002, cam_regs.reg_a003}) << EXPO_SHIFT;
    assign sample_go = (state == S_READ) && xck_rise;

    always_ff @(posedge sys_clock) begin
        if (!sys_resetn) begin
            state       <= S_IDLE;
            rst_low     <= 1'b0;
            expo_cnt    <= '0;
            read_cnt    <= '0;
            capture_ack <= 1'b0;
            cfg_start   <= 1'b0;
            sens_reset  <= 1'b1;
            sens_start  <= 1'b0;
            sens_read   <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            cfg_start   <= 1'b0;
            frame_start <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (capture_req) begin
                        frame_start <= 1'b1;
                        state       <= S_RESET;
                    end
                end
                // reset held low for one period, fall to fall
                S_RESET, S_RESET2: begin
                    if (xck_fall) begin
                        if (!rst_low) begin
                            sens_reset <= 1'b0;
                            rst_low    <= 1'b1;
                        end else begin
                            sens_reset <= 1'b1;
                            rst_low    <= 1'b0;
                            if (state == S_RESET) begin
                                cfg_start <= 1'b1;
                                state     <= S_CONFIG;
                            end else begin
                                state <= S_DONE;
                            end
                        end
                    end
                end
                S_CONFIG: begin
                    if (cfg_done) begin
                        state <= S_START;
                    end
                end
                S_START: begin
                    if (mid_low) begin
                        if (!sens_start) begin
                            sens_start <= 1'b1;
                        end else begin
                            sens_start <= 1'b0;
                            expo_cnt   <= '0;
                            state      <= S_EXPOSE;
                        end
                    end
                end
                S_EXPOSE: begin
                    if (xck_rise) begin
                        if (expo_cnt == expo_len) begin
                            sens_read <= 1'b1;
                            read_cnt  <= '0;
                            state     <= S_READ;
                        end else begin
                            expo_cnt <= expo_cnt + 1'b1;
                        end
                    end
                end
                // one pixel per rise, read drops with the last one
                S_READ: begin
                    if (xck_rise) begin
                        read_cnt <= read_cnt + 1'b1;
                        if (read_cnt == RW'(NPIX - 1)) begin
                            sens_read <= 1'b0;
                            state     <= S_DRAIN;
                        end
                    end
                end
                // last sample settles before the next rise
                S_DRAIN: begin
                    if (xck_rise) begin
                        state <= S_RESET2;
                    end
                end
                S_DONE: begin
                    if (buf_idle) begin
                        capture_ack <= 1'b1;
                        state       <= S_RELEASE;
                    end
                end
                S_RELEASE: begin
                    if (!capture_req) begin
                        capture_ack <= 1'b0;
                        state       <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

endmodule

/* source/pixel_packer.sv */
// pixel-to-byte packer with band tracking and two-slot buffer write queue
`timescale 1ns/1ps

module pixel_packer #(
    parameter int IMG_W = 128
) (
    input  logic                       sys_clock,
    input  logic                       sys_resetn,
    input  logic                       frame_start,
    input  cam_frame_pkg::pix_level_t  level,
    input  logic                       level_valid,
    input  logic                       buf_ack,
    output cam_frame_pkg::buf_wr_t     buf_wr,
    output logic                       buf_req,
    output logic                       flip_buffer,
    output logic                       block_ready,
    output logic                       buf_overrun,
    output logic                       buf_idle
);
    import cam_frame_pkg::*;

    localparam int CW  = $clog2(IMG_W);
    localparam int LW  = $clog2(BAND_LINES);
    localparam int BPL = IMG_W / PIX_PER_BYTE;
    localparam int SW  = 2 * (PIX_PER_BYTE - 1);

    logic [CW-1:0] col;
    logic [LW-1:0] band_line;
    logic [SW-1:0] shreg;
    logic          byte_done;
    logic          pop;
    logic          full0;
    logic          full1;
    buf_wr_t       new_wr;
    buf_wr_t       hold;

    // first pixel of a group ends up in the top bits
    assign byte_done     = level_valid && (col % PIX_PER_BYTE == PIX_PER_BYTE - 1);
    assign new_wr.data   = {shreg, level};
    assign new_wr.offset = 10'(band_line * BPL + col / PIX_PER_BYTE);

    // slot 0 drives buf_wr, slot 1 is the spare
    assign pop      = buf_req && buf_ack;
    assign buf_idle = !full0 && !buf_ack;

    always_ff @(posedge sys_clock) begin
        if (!sys_resetn) begin
            col         <= '0;
            band_line   <= '0;
            full0       <= 1'b0;
            full1       <= 1'b0;
            buf_req     <= 1'b0;
            flip_buffer <= 1'b0;
            block_ready <= 1'b0;
            buf_overrun <= 1'b0;
        end else begin
            block_ready <= 1'b0;
            if (frame_start) begin
                col         <= '0;
                band_line   <= '0;
                buf_overrun <= 1'b0;
            end else if (level_valid) begin
                shreg <= {shreg[SW-3:0], level};
                if (col == CW'(IMG_W - 1)) begin
                    col       <= '0;
                    band_line <= band_line + 1'b1;
                    if (band_line == LW'(BAND_LINES - 1)) begin
                        flip_buffer <= !flip_buffer;
                        block_ready <= 1'b1;
                    end
                end else begin
                    col <= col + 1'b1;
                end
            end
            if (pop) begin
                // write accepted, refill slot 0
                buf_req <= 1'b0;
                if (full1) begin
                    buf_wr <= hold;
                    hold   <= new_wr;
                    full1  <= byte_done;
                end else begin
                    buf_wr <= new_wr;
                    full0  <= byte_done;
                end
            end else begin
                // next request only after the previous ack has dropped
                if (full0 && !buf_req && !buf_ack) begin
                    buf_req <= 1'b1;
                end
                if (byte_done) begin
                    if (!full0) begin
                        buf_wr <= new_wr;
                        full0  <= 1'b1;
                    end else if (!full1) begin
                        hold  <= new_wr;
                        full1 <= 1'b1;
                    end else begin
                        buf_overrun <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

/* source/pixel_quantizer.sv */
// settle delay and three-threshold pixel quantizer
`timescale 1ns/1ps

module pixel_quantizer #(
    parameter int SETTLE = 15
) (
    input  logic                        sys_clock,
    input  logic                        sys_resetn,
    input  logic                        sample_go,
    input  logic [7:0]                  adc_data,
    input  cam_frame_pkg::cam_thresh_t  thresh,
    output cam_frame_pkg::pix_level_t   level,
    output logic                        level_valid
);
    import cam_frame_pkg::*;

    localparam int CW = $clog2(SETTLE + 1);

    logic [CW-1:0] cnt;
    logic          busy;
    pix_level_t    above;

    // number of thresholds reached
    assign above = pix_level_t'(adc_data >= thresh.th0)
                 + pix_level_t'(adc_data >= thresh.th1)
                 + pix_level_t'(adc_data >= thresh.th2);

    always_ff @(posedge sys_clock) begin
        if (!sys_resetn) begin
            cnt         <= '0;
            busy        <= 1'b0;
            level_valid <= 1'b0;
        end else begin
            level_valid <= 1'b0;
            if (sample_go) begin
                busy <= 1'b1;
                cnt  <= CW'(1);
            end else if (busy) begin
                if (cnt == CW'(SETTLE)) begin
                    busy        <= 1'b0;
                    level       <= above;
                    level_valid <= 1'b1;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

endmodule

/* source/reg_serializer.sv */
// configuration word builder and serial shifter with LOAD pulses
`timescale 1ns/1ps

module reg_serializer (
    input  logic                      sys_clock,
    input  logic                      sys_resetn,
    input  cam_sensor_pkg::cam_regs_t cam_regs,
    input  logic                      cfg_start,
    input  logic                      xck_rise,
    input  logic                      xck_fall,
    input  logic                      mid_high,
    output logic                      sens_sin,
    output logic                      sens_load,
    output logic                      cfg_done
);
    import cam_sensor_pkg::*;

    logic        active;
    logic        all_sent;
    logic        bit_out;
    logic        load_pend;
    logic [2:0]  widx;
    logic [3:0]  bidx;
    logic [10:0] word_bits;

    // P and M depend on the capture mode in reg_a000
    function automatic cam_word_t build_word(input logic [2:0] addr, input cam_regs_t r);
        cam_word_t  w;
        logic [7:0] p_val;
        logic [7:0] m_val;
        case (r.reg_a000[2:0])
            3'b011: begin
                p_val = 8'h01;
                m_val = 8'h00;
            end
            3'b101, 3'b111: begin
                p_val = 8'h01;
                m_val = 8'h02;
            end
            default: begin
                p_val = 8'h00;
                m_val = 8'h01;
            end
        endcase
        w.addr = addr;
        case (addr)
            3'd1:    w.data = r.reg_a001;
            3'd2:    w.data = r.reg_a002;
            3'd3:    w.data = r.reg_a003;
            3'd4:    w.data = p_val;
            3'd5:    w.data = m_val;
            3'd6:    w.data = 8'h01;
            3'd7:    w.data = r.reg_a004;
            default: w.data = r.reg_a005;
        endcase
        return w;
    endfunction

    assign word_bits = build_word(REG_ORDER[widx], cam_regs);

    always_ff @(posedge sys_clock) begin
        if (!sys_resetn) begin
            active    <= 1'b0;
            all_sent  <= 1'b0;
            bit_out   <= 1'b0;
            load_pend <= 1'b0;
            widx      <= '0;
            bidx      <= 4'd10;
            sens_sin  <= 1'b0;
            sens_load <= 1'b0;
            cfg_done  <= 1'b0;
        end else begin
            cfg_done <= 1'b0;
            if (cfg_start) begin
                active   <= 1'b1;
                all_sent <= 1'b0;
                bit_out  <= 1'b0;
                widx     <= '0;
                bidx     <= 4'd10;
            end else if (active) begin
                // new bit on the falling edge, sin idles low once all words are out
                if (xck_fall) begin
                    sens_sin <= !all_sent && word_bits[bidx];
                    bit_out  <= !all_sent;
                end
                // sensor took the bit on this rise
                if (xck_rise && bit_out) begin
                    bit_out <= 1'b0;
                    if (bidx == 4'd0) begin
                        load_pend <= 1'b1;
                        bidx      <= 4'd10;
                        widx      <= widx + 3'd1;
                        all_sent  <= (widx == 3'(REG_COUNT - 1));
                    end else begin
                        bidx <= bidx - 4'd1;
                    end
                end
                // load spans one period, mid_high to mid_high
                if (mid_high) begin
                    if (sens_load) begin
                        sens_load <= 1'b0;
                        if (all_sent) begin
                            active   <= 1'b0;
                            cfg_done <= 1'b1;
                        end
                    end else if (load_pend) begin
                        sens_load <= 1'b1;
                        load_pend <= 1'b0;
                    end
                end
            end
        end
    end

endmodule

/* source/xck_gen.sv */
// sensor clock divider with edge and mid-phase event pulses
`timescale 1ns/1ps

module xck_gen #(
    parameter int XCK_HALF = 16
) (
    input  logic sys_clock,
    input  logic sys_resetn,
    output logic sens_xck,
    output logic xck_rise,
    output logic xck_fall,
    output logic mid_high,
    output logic mid_low
);
    localparam int CW = $clog2(XCK_HALF);

    logic [CW-1:0] cnt;
    logic          wrap;
    logic          mid;

    assign wrap = (cnt == CW'(XCK_HALF - 1));
    assign mid  = (cnt == CW'(XCK_HALF / 2 - 1));

    // pulses line up with the cycle in which sens_xck shows the new level
    always_ff @(posedge sys_clock) begin
        if (!sys_resetn) begin
            cnt      <= '0;
            sens_xck <= 1'b0;
            xck_rise <= 1'b0;
            xck_fall <= 1'b0;
            mid_high <= 1'b0;
            mid_low  <= 1'b0;
        end else begin
            cnt      <= wrap ? '0 : cnt + 1'b1;
            xck_rise <= wrap && !sens_xck;
            xck_fall <= wrap && sens_xck;
            mid_high <= mid && sens_xck;
            mid_low  <= mid && !sens_xck;
            if (wrap) begin
                sens_xck <= !sens_xck;
            end
        end
    end

endmodule

/* verif/cam_tb.sv */
// testbench for cam_top with sensor model, buffer model, capture table, checks and timeout
`timescale 1ns/1ps

module cam_tb;
    import cam_sensor_pkg::*;
    import cam_frame_pkg::*;

    localparam int XCK_HALF   = 8;
    localparam int SETTLE     = 6;
    localparam int IMG_W      = 16;
    localparam int IMG_H      = 16;
    localparam int XCK_PERIOD = 2 * XCK_HALF;
    localparam int NPIX       = IMG_W * IMG_H;
    localparam int NROWS      = 3;

    typedef struct packed {
        cam_regs_t   regs;
        cam_thresh_t thr;
        logic [1:0]  ack_delay;
    } row_t;

    // regs a000..a005, thresholds th0..th2, buffer ack delay in cycles
    localparam row_t ROWS [NROWS] = '{
        '{48'h06_12_00_02_34_56, 24'h40_80_C0, 2'd0},
        '{48'h03_A7_00_03_9B_0F, 24'h20_60_E0, 2'd2},
        '{48'h05_3C_00_01_E4_81, 24'h10_50_F0, 2'd3}
    };

    logic        sys_clock   = 1'b0;
    logic        sys_resetn  = 1'b0;
    cam_regs_t   cam_regs    = '0;
    cam_thresh_t thresh      = '0;
    logic        capture_req = 1'b0;
    logic [7:0]  adc_data    = 8'h00;
    logic        buf_ack     = 1'b0;
    logic        capture_ack;
    logic        sens_xck;
    logic        sens_reset;
    logic        sens_sin;
    logic        sens_load;
    logic        sens_start;
    logic        sens_read;
    buf_wr_t     buf_wr;
    logic        buf_req;
    logic        flip_buffer;
    logic        block_ready;
    logic        buf_overrun;

    // model state, written only by the monitor process
    logic        prev_xck;
    logic        prev_load;
    logic        prev_reset;
    logic        prev_read;
    logic        prev_flip;
    logic        prev_start;
    logic        prev_req;
    logic        prev_cap_req;
    logic        prev_cap_ack;
    logic        read_done;
    logic [10:0] sin_shift;
    logic [7:0]  pix;
    logic [10:0] words [$];
    pix_level_t  levels [$];
    buf_wr_t     writes [$];
    int          rst_first;
    int          rst_second;
    int          rst_other;
    int          flips;
    int          blocks;
    int          starts;
    int          ack_wait;

    int          ack_delay   = 0;
    int          cycle_count = 0;

    cam_top #(
        .XCK_HALF(XCK_HALF), .SETTLE(SETTLE), .IMG_W(IMG_W), .IMG_H(IMG_H)
    ) u_dut (
        .sys_clock(sys_clock), .sys_resetn(sys_resetn), .cam_regs(cam_regs),
        .thresh(thresh), .capture_req(capture_req), .capture_ack(capture_ack),
        .adc_data(adc_data), .sens_xck(sens_xck), .sens_reset(sens_reset),
        .sens_sin(sens_sin), .sens_load(sens_load), .sens_start(sens_start),
        .sens_read(sens_read), .buf_wr(buf_wr), .buf_req(buf_req), .buf_ack(buf_ack),
        .flip_buffer(flip_buffer), .block_ready(block_ready), .buf_overrun(buf_overrun)
    );

    always #5 sys_clock = ~sys_clock;

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAILED at time %0t: %s (got %0h, expected %0h)",
                     $time, what, actual, expected);
            $display("SOME TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // sensor word: 3-bit address then data byte, P and M from the mode bits
    function automatic logic [10:0] expected_word(input logic [2:0] addr, input cam_regs_t r);
        logic [7:0] p;
        logic [7:0] m;
        logic [7:0] d;
        p = 8'd0;
        m = 8'd1;
        if (r.reg_a000[2:0] == 3'b011) begin
            p = 8'd1;
            m = 8'd0;
        end else if (r.reg_a000[2:0] == 3'b101 || r.reg_a000[2:0] == 3'b111) begin
            p = 8'd1;
            m = 8'd2;
        end
        case (addr)
            3'd1:    d = r.reg_a001;
            3'd2:    d = r.reg_a002;
            3'd3:    d = r.reg_a003;
            3'd4:    d = p;
            3'd5:    d = m;
            3'd6:    d = 8'h01;
            3'd7:    d = r.reg_a004;
            default: d = r.reg_a005;
        endcase
        return {addr, d};
    endfunction

    function automatic pix_level_t expected_level(input logic [7:0] v, input cam_thresh_t t);
        pix_level_t lvl;
        lvl = 2'd0;
        if (v >= t.th0) lvl = lvl + 2'd1;
        if (v >= t.th1) lvl = lvl + 2'd1;
        if (v >= t.th2) lvl = lvl + 2'd1;
        return lvl;
    endfunction

    // twice the expected length of all captures
    function automatic int timeout_limit();
        int total;
        total = 0;
        for (int i = 0; i < NROWS; i++) begin
            total += 100 + 8 * int'({ROWS[i].regs.reg_a002, ROWS[i].regs.reg_a003}) + NPIX;
        end
        return 2 * total * XCK_PERIOD;
    endfunction

    always @(posedge sys_clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > timeout_limit()) begin
            $display("TIMEOUT: the run did not finish within %0d cycles", timeout_limit());
            $display("SOME TESTS FAILED");
            $fatal(1, "timeout");
        end
    end

    // sensor and buffer models, sampled on the falling edge
    always @(negedge sys_clock) begin
        if (sys_resetn) begin
            if (buf_req && !prev_req)
                check_equal(32'(buf_ack), 32'd0, "buf_req rose while buf_ack high");
            if (!capture_ack && prev_cap_ack)
                check_equal(32'(capture_req), 32'd0, "capture_ack fell while req high");
            // new capture request
            if (capture_req && !prev_cap_req) begin
                words.delete();
                levels.delete();
                writes.delete();
                rst_first  = 0;
                rst_second = 0;
                rst_other  = 0;
                flips      = 0;
                blocks     = 0;
                starts     = 0;
                ack_wait   = 0;
                read_done  = 1'b0;
            end
            if (sens_xck && !prev_xck) begin
                sin_shift = {sin_shift[9:0], sens_sin};
                // next pixel value shows up right after the rise
                if (sens_read) begin
                    pix = 8'($urandom);
                    adc_data <= pix;
                    levels.push_back(expected_level(pix, thresh));
                end
            end
            if (sens_load && !prev_load)
                words.push_back(sin_shift);
            // start follows the complete configuration
            if (sens_start && !prev_start) begin
                starts++;
                check_equal(32'(words.size()), 32'(REG_COUNT),
                            "sens_start before the last LOAD");
            end
            if (!sens_reset && prev_reset) begin
                if (words.size() == 0 && !read_done)
                    rst_first++;
                else if (read_done)
                    rst_second++;
                else
                    rst_other++;
            end
            if (!sens_read && prev_read)
                read_done = 1'b1;
            if (flip_buffer != prev_flip)
                flips++;
            if (block_ready)
                blocks++;
            // buffer side of the write handshake
            if (buf_req && !buf_ack) begin
                if (ack_wait >= ack_delay) begin
                    buf_ack <= 1'b1;
                    writes.push_back(buf_wr);
                    ack_wait = 0;
                end else begin
                    ack_wait++;
                end
            end else if (!buf_req && buf_ack) begin
                buf_ack <= 1'b0;
            end
        end
        prev_xck     = sens_xck;
        prev_load    = sens_load;
        prev_reset   = sens_reset;
        prev_read    = sens_read;
        prev_flip    = flip_buffer;
        prev_start   = sens_start;
        prev_req     = buf_req;
        prev_cap_req = capture_req;
        prev_cap_ack = capture_ack;
    end

    task automatic run_capture(input int r);
        row_t    row;
        buf_wr_t exp_wr [$];
        logic [7:0] acc;
        int      col;
        int      line;
        row = ROWS[r];
        acc = 8'h00;
        @(negedge sys_clock);
        cam_regs  <= row.regs;
        thresh    <= row.thr;
        ack_delay <= int'(row.ack_delay);
        @(negedge sys_clock);
        capture_req <= 1'b1;
        @(negedge sys_clock);
        while (!capture_ack) @(negedge sys_clock);
        capture_req <= 1'b0;
        @(negedge sys_clock);
        while (capture_ack) @(negedge sys_clock);

        check_equal(32'(words.size()), 32'd8, $sformatf("row %0d LOAD count", r));
        for (int i = 0; i < 8; i++) begin
            check_equal(32'(words[i]), 32'(expected_word(3'((i + 1) % 8), row.regs)),
                        $sformatf("row %0d config word %0d", r, i));
        end
        check_equal(32'(starts), 32'd1, $sformatf("row %0d sens_start pulses", r));
        check_equal(32'(rst_first), 32'd1, $sformatf("row %0d reset before config", r));
        check_equal(32'(rst_second), 32'd1, $sformatf("row %0d reset after read", r));
        check_equal(32'(rst_other), 32'd0, $sformatf("row %0d stray reset pulse", r));
        check_equal(32'(levels.size()), 32'(NPIX), $sformatf("row %0d pixel count", r));

        // four pixels per byte, first pixel in the top bits
        for (int k = 0; k < NPIX; k++) begin
            col = k % IMG_W;
            line = k / IMG_W;
            acc = {acc[5:0], levels[k]};
            if (col % PIX_PER_BYTE == PIX_PER_BYTE - 1) begin
                exp_wr.push_back({10'((line % BAND_LINES) * (IMG_W / PIX_PER_BYTE)
                                      + col / PIX_PER_BYTE), acc});
            end
        end
        check_equal(32'(writes.size()), 32'(NPIX / 4), $sformatf("row %0d write count", r));
        for (int i = 0; i < exp_wr.size(); i++) begin
            check_equal(32'(writes[i]), 32'(exp_wr[i]), $sformatf("row %0d write %0d", r, i));
        end
        check_equal(32'(flips), 32'(IMG_H / 8), $sformatf("row %0d flip_buffer toggles", r));
        check_equal(32'(blocks), 32'(IMG_H / 8), $sformatf("row %0d block_ready pulses", r));
        check_equal(32'(buf_overrun), 32'd0, $sformatf("row %0d buf_overrun", r));
    endtask

    initial begin
        void'($urandom(32'h9171));
        repeat (16) @(negedge sys_clock);
        check_equal(32'({capture_ack, buf_req, sens_load, sens_start, sens_read, sens_sin,
                         sens_xck, flip_buffer, block_ready, buf_overrun, sens_reset}),
                    32'h001, "control outputs in reset");
        sys_resetn <= 1'b1;
        for (int r = 0; r < NROWS; r++) begin
            run_capture(r);
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule
